// ==== Makefile ====
TOP := aformDecoderTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f project.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== hw/aformDecodeStage.sv ====
`timescale 1ns/1ns

module aformDecodeStage #(
    parameter int unsigned AddrWidth  = 64,
    parameter int unsigned PidWidth   = 20,
    parameter int unsigned TidWidth   = 16,
    parameter int unsigned MajIdWidth = 64
) (
    input  logic                  clock_i,
    input  logic                  arstN_i,

    input  logic                  instValid_i,
    input  aformPkg::instClassE   class_i,
    input  aformPkg::microOpS     microOp_i,
    input  logic [AddrWidth-1:0]  instAddr_i,
    input  logic [PidWidth-1:0]   instPid_i,
    input  logic [TidWidth-1:0]   instTid_i,
    input  logic [MajIdWidth-1:0] instMajId_i,

    output logic                  decodeValid_o,
    output aformPkg::microOpS     microOp_o,
    output logic [AddrWidth-1:0]  outAddr_o,
    output logic [PidWidth-1:0]   outPid_o,
    output logic [TidWidth-1:0]   outTid_o,
    output logic [MajIdWidth-1:0] outMajId_o
);

    import aformPkg::*;

    logic accept; // Strobe carrying a legal A-form word

    assign accept = instValid_i && (class_i != ClsIllegal);

    always_ff @(posedge clock_i or negedge arstN_i) begin
        if (!arstN_i) begin
            decodeValid_o <= 1'b0;
        end else begin
            decodeValid_o <= accept; // One cycle pulse per legal word
        end
    end

    // Payload only moves on a legal strobe, otherwise holds
    always_ff @(posedge clock_i) begin
        if (accept) begin
            microOp_o  <= microOp_i;
            outAddr_o  <= instAddr_i;
            outPid_o   <= instPid_i;
            outTid_o   <= instTid_i;
            outMajId_o <= instMajId_i;
        end
    end

    // Only the FP and CR units have A-form users
    validUnitA: assert property (
        @(posedge clock_i) disable iff (!arstN_i)
        decodeValid_o |-> (microOp_o.unit inside {UnitFp, UnitCr})
    ) else $error("Decoded micro-op targets unit %0d", microOp_o.unit);

    // The emitted operand T is always a written register
    destWriteA: assert property (
        @(posedge clock_i) disable iff (!arstN_i)
        decodeValid_o |-> (microOp_o.opT.kind == KindReg && microOp_o.opT.access == AccWrite)
    ) else $error("Decoded micro-op has no written target");

endmodule

// ==== hw/aformDecoder.sv ====
`timescale 1ns/1ns

module aformDecoder #(
    parameter int unsigned AddrWidth  = 64,
    parameter int unsigned PidWidth   = 20,
    parameter int unsigned TidWidth   = 16,
    parameter int unsigned MajIdWidth = 64
) (
    input  logic                              clock_i,
    input  logic                              arstN_i,

    input  logic                              instValid_i,
    input  logic [0:aformPkg::InstWidth-1]    instruction_i, // POWER bit order, bit 0 is MSB
    input  logic [AddrWidth-1:0]              instAddr_i,
    input  logic [PidWidth-1:0]               instPid_i,
    input  logic [TidWidth-1:0]               instTid_i,
    input  logic [MajIdWidth-1:0]             instMajId_i,

    output logic                              decodeValid_o,
    output aformPkg::microOpS                 microOp_o,
    output logic [AddrWidth-1:0]              outAddr_o,
    output logic [PidWidth-1:0]               outPid_o,
    output logic [TidWidth-1:0]               outTid_o,
    output logic [MajIdWidth-1:0]             outMajId_o
);

    import aformPkg::*;

    primaryOpE          primOp;
    logic [XoWidth-1:0] xo;
    logic [RegWidth-1:0] rt, ra, rb, rc;
    instClassE          instClass;
    funcUnitE           unit;
    logic               single;
    operandS            opT, opA, opB, opC;
    microOpS            microOp;

    // A-form field slicing
    assign primOp = primaryOpE'(instruction_i[0:5]);
    assign rt     = instruction_i[6:10];
    assign ra     = instruction_i[11:15];
    assign rb     = instruction_i[16:20];
    assign rc     = instruction_i[21:25];
    assign xo     = instruction_i[26:30];

    aformOpcodeTable i_opcodeTable (
        .primOp_i (primOp),
        .xo_i     (xo),
        .class_o  (instClass),
        .unit_o   (unit),
        .single_o (single)
    );

    aformOperandMap i_operandMap (
        .class_i (instClass),
        .rt_i    (rt),
        .ra_i    (ra),
        .rb_i    (rb),
        .rc_i    (rc),
        .opT_o   (opT),
        .opA_o   (opA),
        .opB_o   (opB),
        .opC_o   (opC)
    );

    always_comb begin
        microOp.primOp = primOp;
        microOp.xo     = xo;
        microOp.unit   = unit;
        microOp.single = single;
        microOp.rc     = instruction_i[31]; // Rc bit
        microOp.opT    = opT;
        microOp.opA    = opA;
        microOp.opB    = opB;
        microOp.opC    = opC;
    end

    aformDecodeStage #(
        .AddrWidth  (AddrWidth),
        .PidWidth   (PidWidth),
        .TidWidth   (TidWidth),
        .MajIdWidth (MajIdWidth)
    ) i_decodeStage (
        .clock_i       (clock_i),
        .arstN_i       (arstN_i),
        .instValid_i   (instValid_i),
        .class_i       (instClass),
        .microOp_i     (microOp),
        .instAddr_i    (instAddr_i),
        .instPid_i     (instPid_i),
        .instTid_i     (instTid_i),
        .instMajId_i   (instMajId_i),
        .decodeValid_o (decodeValid_o),
        .microOp_o     (microOp_o),
        .outAddr_o     (outAddr_o),
        .outPid_o      (outPid_o),
        .outTid_o      (outTid_o),
        .outMajId_o    (outMajId_o)
    );

endmodule

// ==== hw/aformOpcodeTable.sv ====
`timescale 1ns/1ns

module aformOpcodeTable (
    input  aformPkg::primaryOpE            primOp_i,
    input  logic [aformPkg::XoWidth-1:0]   xo_i,
    output aformPkg::instClassE            class_o,
    output aformPkg::funcUnitE             unit_o,
    output logic                           single_o
);

    import aformPkg::*;

    // The single and double FP rows share one XO table.
    // Select (XO 23) only exists in double precision.
    function automatic instClassE fpClass(
        input logic [XoWidth-1:0] xo,
        input logic               allowSelect
    );
        instClassE cls;
        cls = ClsIllegal;
        case (xo)
            5'd18,                                  // fdiv
            5'd20,                                  // fsub
            5'd21: cls = ClsFpTwoOp;                // fadd
            5'd25: cls = ClsFpMul;                  // fmul
            5'd22,                                  // fsqrt
            5'd24,                                  // fre
            5'd26: cls = ClsFpOneOp;                // frsqrte
            5'd28,                                  // fmsub
            5'd29,                                  // fmadd
            5'd30,                                  // fnmsub
            5'd31: cls = ClsFpThreeOp;              // fnmadd
            5'd23: begin                            // fsel
                if (allowSelect) begin
                    cls = ClsFpThreeOp;
                end
            end
            default: cls = ClsIllegal;
        endcase
        return cls;
    endfunction

    always_comb begin
        class_o  = ClsIllegal;
        unit_o   = UnitFp;
        single_o = 1'b0;
        case (primOp_i)
            PrimInt: begin
                case (xo_i)
                    5'd15: begin // isel
                        class_o = ClsIntSelect;
                        unit_o  = UnitCr;
                    end
                    default: class_o = ClsIllegal;
                endcase
            end
            PrimFpDouble: begin
                class_o = fpClass(xo_i, 1'b1);
            end
            PrimFpSingle: begin
                class_o  = fpClass(xo_i, 1'b0);
                single_o = 1'b1;
            end
            default: class_o = ClsIllegal;
        endcase
    end

    // A single-precision word must always go to the FP unit
    always_comb begin
        assert (!single_o || unit_o == UnitFp)
            else $error("Single flag set for a non-FP unit");
    end

endmodule

// ==== hw/aformOperandMap.sv ====
`timescale 1ns/1ns

module aformOperandMap (
    input  aformPkg::instClassE           class_i,
    input  logic [aformPkg::RegWidth-1:0] rt_i,
    input  logic [aformPkg::RegWidth-1:0] ra_i,
    input  logic [aformPkg::RegWidth-1:0] rb_i,
    input  logic [aformPkg::RegWidth-1:0] rc_i,
    output aformPkg::operandS             opT_o,
    output aformPkg::operandS             opA_o,
    output aformPkg::operandS             opB_o,
    output aformPkg::operandS             opC_o
);

    import aformPkg::*;

    localparam operandS UnusedOp = '{regNum: '0, kind: KindUnused, access: AccNone};

    function automatic operandS makeOp(
        input logic [RegWidth-1:0] regNum,
        input operandKindE         kind,
        input accessE              access
    );
        operandS op;
        op.regNum = regNum;
        op.kind   = kind;
        op.access = access;
        return op;
    endfunction

    always_comb begin
        opT_o = UnusedOp;
        opA_o = UnusedOp;
        opB_o = UnusedOp;
        opC_o = UnusedOp;

        if (class_i != ClsIllegal) begin
            opT_o = makeOp(rt_i, KindReg, AccWrite); // Every A-form writes RT
        end

        case (class_i)
            ClsIntSelect: begin
                // RA of 0 means the constant zero, not GPR0
                if (ra_i == '0) begin
                    opA_o = makeOp('0, KindZero, AccRead);
                end else begin
                    opA_o = makeOp(ra_i, KindReg, AccRead);
                end
                opB_o = makeOp(rb_i, KindReg, AccRead);
                opC_o = makeOp(rc_i, KindReg, AccRead); // CR bit selector
            end
            ClsFpTwoOp: begin
                opA_o = makeOp(ra_i, KindReg, AccRead);
                opB_o = makeOp(rb_i, KindReg, AccRead);
            end
            ClsFpMul: begin
                opA_o = makeOp(ra_i, KindReg, AccRead);
                opC_o = makeOp(rc_i, KindReg, AccRead); // Multiplier comes from FRC
            end
            ClsFpOneOp: begin
                opB_o = makeOp(rb_i, KindReg, AccRead);
            end
            ClsFpThreeOp: begin
                opA_o = makeOp(ra_i, KindReg, AccRead);
                opB_o = makeOp(rb_i, KindReg, AccRead);
                opC_o = makeOp(rc_i, KindReg, AccRead);
            end
            default: begin
                // Illegal class leaves every slot unused
            end
        endcase
    end

endmodule

// ==== hw/aformPkg.sv ====
package aformPkg;

    // Instruction field widths
    localparam int unsigned OpcodeWidth = 6;
    localparam int unsigned RegWidth    = 5;
    localparam int unsigned XoWidth     = 5;
    localparam int unsigned InstWidth   = 32;

    // Primary opcodes that carry A-form instructions
    typedef enum logic [OpcodeWidth-1:0] {
        PrimInt      = 6'd31, // Integer select lives here
        PrimFpSingle = 6'd59,
        PrimFpDouble = 6'd63
    } primaryOpE;

    // Instruction classes that share one operand pattern
    typedef enum logic [2:0] {
        ClsIllegal,   // Not an A-form word
        ClsIntSelect, // isel
        ClsFpTwoOp,   // Add, subtract, divide
        ClsFpMul,     // Multiply, A times C
        ClsFpOneOp,   // Square root and estimates
        ClsFpThreeOp  // Multiply-add forms and select
    } instClassE;

    // Execution unit codes, shared with the rest of the back end
    typedef enum logic [2:0] {
        UnitFx = 3'd0,
        UnitFp = 3'd1,
        UnitVx = 3'd2,
        UnitCr = 3'd3,
        UnitLs = 3'd4
    } funcUnitE;

    // What an operand slot holds
    typedef enum logic [1:0] {
        KindUnused,
        KindReg,
        KindZero // Literal zero in place of a register
    } operandKindE;

    // How the back end touches the operand
    typedef enum logic [1:0] {
        AccNone,
        AccRead,
        AccWrite
    } accessE;

    // One operand descriptor
    typedef struct packed {
        logic [RegWidth-1:0] regNum;
        operandKindE         kind;
        accessE              access;
    } operandS;

    // Decoded micro-op as handed to the back end
    typedef struct packed {
        primaryOpE          primOp;
        logic [XoWidth-1:0] xo;
        funcUnitE           unit;
        logic               single; // Single precision result
        logic               rc;     // Record bit, updates CR
        operandS            opT;
        operandS            opA;
        operandS            opB;
        operandS            opC;
    } microOpS;

endpackage

// ==== project.f ====
+incdir+sim
hw/aformPkg.sv
hw/aformOpcodeTable.sv
hw/aformOperandMap.sv
hw/aformDecodeStage.sv
hw/aformDecoder.sv
sim/aformDecoderTb.sv

// ==== sim/aformRefModel.svh ====
`ifndef AFORM_REF_MODEL_SVH
`define AFORM_REF_MODEL_SVH

// Source operand descriptor, read if used, empty otherwise
function automatic operandS refOperand(
    input logic       used,
    input logic [4:0] regNum
);
    operandS op;
    if (used) begin
        op = '{regNum: regNum, kind: KindReg, access: AccRead};
    end else begin
        op = '{regNum: 5'd0, kind: KindUnused, access: AccNone};
    end
    return op;
endfunction

// Expected decode of one word, word[31] is POWER bit 0
function automatic void refDecode(
    input  logic [31:0] word,
    output logic        legal,
    output microOpS     op
);
    logic [5:0] prim;
    logic [4:0] xo;
    logic       readA;
    logic       readB;
    logic       readC;
    logic       isSelect;
    prim     = word[31:26];
    xo       = word[5:1];
    legal    = 1'b0;
    readA    = 1'b0;
    readB    = 1'b0;
    readC    = 1'b0;
    isSelect = 1'b0;
    op        = '0;
    op.primOp = primaryOpE'(prim);
    op.xo     = xo;
    op.rc     = word[0];
    op.unit   = UnitFp;
    if (prim == 6'd31 && xo == 5'd15) begin // isel
        legal    = 1'b1;
        isSelect = 1'b1;
        op.unit  = UnitCr;
        {readA, readB, readC} = 3'b111;
    end else if (prim == 6'd59 || prim == 6'd63) begin
        legal     = 1'b1;
        op.single = (prim == 6'd59);
        case (xo)
            5'd18, 5'd20, 5'd21: {readA, readB} = 2'b11;           // Divide, sub, add
            5'd25: {readA, readC} = 2'b11;                          // Multiply
            5'd22, 5'd24, 5'd26: readB = 1'b1;                      // Sqrt, estimates
            5'd28, 5'd29, 5'd30, 5'd31: {readA, readB, readC} = 3'b111;
            5'd23: begin
                if (prim == 6'd63) begin                             // fsel, double only
                    {readA, readB, readC} = 3'b111;
                end else begin
                    legal = 1'b0;
                end
            end
            default: legal = 1'b0;
        endcase
    end
    if (legal) begin
        op.opT = '{regNum: word[25:21], kind: KindReg, access: AccWrite};
        op.opA = refOperand(readA, word[20:16]);
        op.opB = refOperand(readB, word[15:11]);
        op.opC = refOperand(readC, word[10:6]);
        if (isSelect && word[20:16] == 5'd0) begin
            op.opA = '{regNum: 5'd0, kind: KindZero, access: AccRead}; // RA 0 reads as zero
        end
    end
endfunction

`endif

// ==== sim/aformDecoderTb.sv ====
`timescale 1ns/1ns

module aformDecoderTb;

    import aformPkg::*;

    `include "aformRefModel.svh"

    typedef struct packed {
        microOpS     op;
        logic [63:0] addr;
        logic [19:0] pid;
        logic [15:0] tid;
        logic [63:0] majId;
        logic [31:0] cycle; // Cycle count when the output must show
    } expectS;

    logic        clock;
    logic        arstN;
    logic        instValid;
    logic [31:0] instruction;
    logic [63:0] instAddr;
    logic [19:0] instPid;
    logic [15:0] instTid;
    logic [63:0] instMajId;
    logic        decodeValid;
    microOpS     microOp;
    logic [63:0] outAddr;
    logic [19:0] outPid;
    logic [15:0] outTid;
    logic [63:0] outMajId;

    logic [31:0] cycleCount;
    integer      seed = 97312;
    expectS      expQ[$];
    logic [4:0]  fpXoList [11] = '{5'd18, 5'd20, 5'd21, 5'd22, 5'd24, 5'd25,
                                   5'd26, 5'd28, 5'd29, 5'd30, 5'd31};

    aformDecoder i_dut (
        .clock_i       (clock),
        .arstN_i       (arstN),
        .instValid_i   (instValid),
        .instruction_i (instruction),
        .instAddr_i    (instAddr),
        .instPid_i     (instPid),
        .instTid_i     (instTid),
        .instMajId_i   (instMajId),
        .decodeValid_o (decodeValid),
        .microOp_o     (microOp),
        .outAddr_o     (outAddr),
        .outPid_o      (outPid),
        .outTid_o      (outTid),
        .outMajId_o    (outMajId)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h",
                                      name, actual, expected));
        end
    endtask

    // Random register fields and Rc around a fixed opcode pair
    function automatic logic [31:0] makeWord(input logic [5:0] prim, input logic [4:0] xo);
        logic [31:0] r;
        r = $random(seed);
        return {prim, r[25:6], xo, r[0]};
    endfunction

    task automatic sendWord(input logic [31:0] word);
        logic        legal;
        microOpS     op;
        expectS      e;
        logic [31:0] r;
        @(negedge clock);
        r           = $random(seed);
        instValid   = 1'b1;
        instruction = word;
        instAddr    = {$random(seed), $random(seed)};
        instPid     = r[19:0];
        instTid     = r[31:16];
        instMajId   = {$random(seed), $random(seed)};
        refDecode(word, legal, op);
        if (legal) begin
            e.op    = op;
            e.addr  = instAddr;
            e.pid   = instPid;
            e.tid   = instTid;
            e.majId = instMajId;
            e.cycle = cycleCount + 1;
            expQ.push_back(e);
        end
    endtask

    task automatic idleCycle();
        @(negedge clock);
        instValid   = 1'b0;
        instruction = $random(seed); // Junk under a low strobe
    endtask

    task automatic drainQueue();
        int waited;
        waited = 0;
        while (expQ.size() != 0 && waited < 50) begin
            @(posedge clock);
            waited++;
        end
        if (expQ.size() != 0) begin
            stopWithFailure("Timed out waiting for pending words to leave the decoder");
        end
    endtask

    // Scoreboard, sampled mid-cycle
    always @(negedge clock) begin
        expectS e;
        if (arstN && decodeValid) begin
            if (expQ.size() == 0) begin
                stopWithFailure("decodeValid_o went high with no legal word pending");
            end else begin
                e = expQ.pop_front();
                checkValue("output cycle", 64'(cycleCount), 64'(e.cycle));
                checkValue("microOp_o.primOp", 64'(microOp.primOp), 64'(e.op.primOp));
                checkValue("microOp_o.xo", 64'(microOp.xo), 64'(e.op.xo));
                checkValue("microOp_o.unit", 64'(microOp.unit), 64'(e.op.unit));
                checkValue("microOp_o.single", 64'(microOp.single), 64'(e.op.single));
                checkValue("microOp_o.rc", 64'(microOp.rc), 64'(e.op.rc));
                checkValue("microOp_o.opT", 64'(microOp.opT), 64'(e.op.opT));
                checkValue("microOp_o.opA", 64'(microOp.opA), 64'(e.op.opA));
                checkValue("microOp_o.opB", 64'(microOp.opB), 64'(e.op.opB));
                checkValue("microOp_o.opC", 64'(microOp.opC), 64'(e.op.opC));
                checkValue("outAddr_o", outAddr, e.addr);
                checkValue("outPid_o", 64'(outPid), 64'(e.pid));
                checkValue("outTid_o", 64'(outTid), 64'(e.tid));
                checkValue("outMajId_o", outMajId, e.majId);
            end
        end
    end

    initial begin
        logic [31:0] word;
        logic [31:0] r;
        logic [5:0]  prim;
        clock       = 1'b0;
        arstN       = 1'b0;
        cycleCount  = '0;
        instValid   = 1'b0;
        instruction = '0;
        instAddr    = '0;
        instPid     = '0;
        instTid     = '0;
        instMajId   = '0;

        repeat (4) begin
            @(posedge clock);
            @(negedge clock);
            checkValue("decodeValid_o", 64'(decodeValid), 64'd0);
        end
        arstN = 1'b1;
        repeat (3) idleCycle(); // Must stay quiet before the first strobe

        // Every kept opcode pair
        sendWord(makeWord(6'd31, 5'd15));
        idleCycle();
        for (int i = 0; i < 11; i++) begin
            sendWord(makeWord(6'd63, fpXoList[i]));
            idleCycle();
            sendWord(makeWord(6'd59, fpXoList[i]));
            idleCycle();
        end
        sendWord(makeWord(6'd63, 5'd23)); // fsel
        idleCycle();

        // isel with RA zero and nonzero, output read one cycle after the strobe
        word = makeWord(6'd31, 5'd15);
        word[20:16] = 5'd0;
        sendWord(word);
        idleCycle();
        checkValue("decodeValid_o", 64'(decodeValid), 64'd1);
        checkValue("microOp_o.opA.kind", 64'(microOp.opA.kind), 64'(KindZero));
        word[20:16] = 5'd9;
        sendWord(word);
        idleCycle();
        checkValue("decodeValid_o", 64'(decodeValid), 64'd1);
        checkValue("microOp_o.opA.kind", 64'(microOp.opA.kind), 64'(KindReg));
        checkValue("microOp_o.opA.access", 64'(microOp.opA.access), 64'(AccRead));

        // Illegal words
        for (int i = 0; i < 20; i++) begin
            r    = $random(seed);
            prim = r[5:0];
            if (prim == 6'd31 || prim == 6'd59 || prim == 6'd63) begin
                prim = 6'd0;
            end
            sendWord(makeWord(prim, r[10:6]));
        end
        for (int x = 0; x < 18; x++) begin
            sendWord(makeWord(6'd63, 5'(x)));
            sendWord(makeWord(6'd59, 5'(x)));
        end
        sendWord(makeWord(6'd63, 5'd19));
        sendWord(makeWord(6'd59, 5'd19));
        sendWord(makeWord(6'd59, 5'd23)); // No single-precision select
        sendWord(makeWord(6'd31, 5'd14));
        sendWord(makeWord(6'd31, 5'd16));
        idleCycle();

        // Back-to-back mix of legal and illegal strobes
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: prim = 6'd31;
                2'd1: prim = 6'd59;
                2'd2: prim = 6'd63;
                default: prim = r[7:2];
            endcase
            if (prim == 6'd31 && r[13]) begin
                sendWord(makeWord(prim, 5'd15));
            end else begin
                sendWord(makeWord(prim, r[12:8]));
            end
        end
        idleCycle();

        drainQueue();
        repeat (4) idleCycle();
        $display("All checks passed");
        $finish;
    end

endmodule
